// File: project.f
rtl/adc_pkg.sv
rtl/adc_controller.sv
rtl/clk_sync.sv
rtl/oversample_filter.sv
rtl/adc_frontend.sv
sim/adc_frontend_assertions.sv
sim/adc_model.sv
sim/tb_adc_frontend.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_adc_frontend
RTL_TOP    ?= adc_frontend
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Simulation failed
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

RTL_SRCS := $(filter rtl/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run did not pass, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_adc_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_adc_frontend;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 10;
    localparam int WAIT_LIMIT = 2000;
    localparam logic [31:0] SEED = 32'h0fa4_f358;
    localparam int SAMPLES = 1 << adc_pkg::OSR_LOG2;
    localparam longint FULL_SCALE = longint'(1) << adc_pkg::W_DATA;
    // levels that wait_level can watch
    localparam int PIN_RESULT = 0;
    localparam int PIN_CNV = 1;
    localparam int PIN_SCLK = 2;

    logic                       sync_clk_in;
    logic                       reset_in;
    logic                       sdo_a;
    logic                       sdo_b;
    logic                       cnv;
    logic                       sclk;
    logic [adc_pkg::W_MUX-1:0]  mux_sel;
    logic                       result_valid;
    logic [adc_pkg::W_CHS-1:0]  result_chan;
    logic [adc_pkg::W_DATA-1:0] result_data;

    // model table, swapped in only while reset is high
    logic [adc_pkg::W_DATA-1:0] base_table [adc_pkg::N_ADC];
    logic [adc_pkg::W_DATA-1:0] next_table [adc_pkg::N_ADC];

    int error_count;
    int check_count;
    bit aborted;
    // results since reset, overall and per channel
    int result_idx;
    int result_n [adc_pkg::N_ADC];

    adc_frontend DUT (
        .sync_clk_in  (sync_clk_in),
        .reset_in     (reset_in),
        .sdo_a        (sdo_a),
        .sdo_b        (sdo_b),
        .cnv          (cnv),
        .sclk         (sclk),
        .mux_sel      (mux_sel),
        .result_valid (result_valid),
        .result_chan  (result_chan),
        .result_data  (result_data)
    );

    adc_model model (
        .reset_in   (reset_in),
        .cnv        (cnv),
        .sclk       (sclk),
        .mux_sel    (mux_sel),
        .base_table (base_table),
        .sdo_a      (sdo_a),
        .sdo_b      (sdo_b)
    );

    bind adc_frontend adc_frontend_assertions u_assertions (
        .sync_clk_in  (sync_clk_in),
        .reset_in     (reset_in),
        .cnv          (cnv),
        .sclk         (sclk),
        .dv_out       (sync_dv),
        .chan_out     (sync_chan),
        .result_valid (result_valid)
    );

    initial begin
        sync_clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) sync_clk_in = ~sync_clk_in;
    end

    //////////////////////////////////////////////////////////////////////
    // expected values
    //////////////////////////////////////////////////////////////////////

    // chip a then chip b for each mux step, 0,4,1,5,...
    function automatic int chan_at(int idx);
        int pos;
        pos = idx % adc_pkg::N_ADC;
        return (pos % 2 == 0) ? pos / 2 : pos / 2 + adc_pkg::N_MUX;
    endfunction

    // floor of the mean of block n, sample k is base+k modulo full scale
    function automatic longint block_mean(logic [adc_pkg::W_DATA-1:0] base, int n);
        longint sum;
        sum = 0;
        for (int j = 0; j < SAMPLES; j++) begin
            sum += (longint'(base) + longint'(n * SAMPLES + j)) % FULL_SCALE;
        end
        return sum / SAMPLES;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks and waits
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(string what, longint got, longint expected);
        check_count++;
        assert (got == expected) else begin
            error_count++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic check_idle(string when);
        check_value($sformatf("cnv %s", when), longint'(cnv), 0);
        check_value($sformatf("sclk %s", when), longint'(sclk), 0);
        check_value($sformatf("mux_sel %s", when), longint'(mux_sel), 0);
        check_value($sformatf("result_valid %s", when), longint'(result_valid), 0);
    endtask

    // polls at falling edges, a miss stops the remaining tests
    task automatic wait_level(string name, int which);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
            @(negedge sync_clk_in);
            case (which)
                PIN_RESULT: seen = result_valid;
                PIN_CNV:    seen = cnv;
                default:    seen = sclk;
            endcase
        end
        if (!seen) begin
            $display("Timeout: %s did not go high within %0d cycles", name, WAIT_LIMIT);
            error_count++;
            aborted = 1'b1;
        end
    endtask

    // new table goes in while the model and DUT are held in reset
    task automatic apply_reset();
        @(negedge sync_clk_in);
        reset_in = 1'b1;
        base_table = next_table;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge sync_clk_in);
            check_idle("in reset");
        end
        reset_in = 1'b0;
        result_idx = 0;
        for (int i = 0; i < adc_pkg::N_ADC; i++) begin
            result_n[i] = 0;
        end
    endtask

    task automatic collect_results(int count);
        int ch;
        for (int r = 0; r < count && !aborted; r++) begin
            wait_level("result_valid", PIN_RESULT);
            if (!aborted) begin
                ch = int'(result_chan);
                check_value($sformatf("channel of result %0d", result_idx),
                            longint'(ch), longint'(chan_at(result_idx)));
                check_value($sformatf("mean %0d of channel %0d", result_n[ch], ch),
                            longint'(result_data), block_mean(base_table[ch], result_n[ch]));
                result_n[ch]++;
                result_idx++;
            end
        end
    endtask

    task automatic load_constant_table();
        int v;
        for (int i = 0; i < adc_pkg::N_ADC; i++) begin
            v = i * 'h1111 + 'h40;
            next_table[i] = v[adc_pkg::W_DATA-1:0];
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_outputs_idle();
        for (int i = 0; i < adc_pkg::N_ADC; i++) begin
            next_table[i] = '0;
        end
        apply_reset();
        // no shifting or results during the first conversion wait
        for (int i = 0; i < adc_pkg::CONV_CYCLES; i++) begin
            @(negedge sync_clk_in);
            check_value("sclk after reset", longint'(sclk), 0);
            check_value("mux_sel after reset", longint'(mux_sel), 0);
            check_value("result_valid after reset", longint'(result_valid), 0);
        end
    endtask

    // two blocks per channel, so the order is seen to repeat
    task automatic constant_table_averages();
        if (aborted) return;
        load_constant_table();
        apply_reset();
        collect_results(2 * adc_pkg::N_ADC);
    endtask

    task automatic random_table_averages();
        logic [31:0] rnd;
        if (aborted) return;
        for (int i = 0; i < adc_pkg::N_ADC; i++) begin
            rnd = $urandom;
            next_table[i] = rnd[adc_pkg::W_DATA-1:0];
        end
        apply_reset();
        collect_results(adc_pkg::N_ADC);
    endtask

    // second block wraps past full scale in the model
    task automatic full_scale_averages();
        longint v;
        if (aborted) return;
        for (int i = 0; i < adc_pkg::N_ADC; i++) begin
            v = FULL_SCALE - 5 + longint'(i % 5);
            next_table[i] = v[adc_pkg::W_DATA-1:0];
        end
        apply_reset();
        collect_results(2 * adc_pkg::N_ADC);
    endtask

    task automatic reset_mid_conversion();
        if (aborted) return;
        load_constant_table();
        apply_reset();
        // partial sums build up on the first channels
        for (int i = 0; i < 6 && !aborted; i++) begin
            wait_level("cnv", PIN_CNV);
        end
        wait_level("sclk", PIN_SCLK);
        if (aborted) return;
        apply_reset();
        collect_results(adc_pkg::N_ADC);
    endtask

    initial begin
        reset_in = 1'b0;
        error_count = 0;
        check_count = 0;
        aborted = 1'b0;
        for (int i = 0; i < adc_pkg::N_ADC; i++) begin
            base_table[i] = '0;
            next_table[i] = '0;
        end
        void'($urandom(SEED));
        reset_outputs_idle();
        constant_table_averages();
        random_table_averages();
        full_scale_averages();
        reset_mid_conversion();
        $display("Checks %0d, errors %0d, assertion failures %0d, aborted %0d",
                 check_count, error_count, DUT.u_assertions.assert_fails, aborted);
        if (error_count == 0 && DUT.u_assertions.assert_fails == 0 && !aborted) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/adc_model.sv
`timescale 1ns/1ps
`default_nettype none

module adc_model (
    input  wire logic                       reset_in,
    // converter pins as the chips see them
    input  wire logic                       cnv,
    input  wire logic                       sclk,
    input  wire logic [adc_pkg::W_MUX-1:0]  mux_sel,
    // analog level behind each channel, a then b chip
    input  wire logic [adc_pkg::W_DATA-1:0] base_table [adc_pkg::N_ADC],
    output logic                            sdo_a,
    output logic                            sdo_b
);

    //////////////////////////////////////////////////////////////////////
    // per channel state
    //////////////////////////////////////////////////////////////////////

    // conversions per channel since reset
    int unsigned conv_cnt [adc_pkg::N_ADC];
    // output shift registers of both chips
    logic [adc_pkg::W_DATA-1:0] shift_a = '0;
    logic [adc_pkg::W_DATA-1:0] shift_b = '0;
    // channels behind the current mux input
    int ch_a;
    int ch_b;

    always_comb begin
        ch_a = int'(mux_sel);
        ch_b = ch_a + adc_pkg::N_MUX;
    end

    // table entry plus conversion count, wraps at full scale
    function automatic logic [adc_pkg::W_DATA-1:0] converted(int ch);
        logic [31:0] k;
        k = conv_cnt[ch];
        return base_table[ch] + k[adc_pkg::W_DATA-1:0];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // conversion and serial output
    //////////////////////////////////////////////////////////////////////

    // value latched on cnv, msb shows at once
    // next bit appears on each falling sclk
    always @(posedge cnv or negedge sclk or posedge reset_in) begin
        if (reset_in) begin
            for (int i = 0; i < adc_pkg::N_ADC; i++) begin
                conv_cnt[i] <= 0;
            end
            shift_a <= '0;
            shift_b <= '0;
        end else if (cnv) begin
            shift_a <= converted(ch_a);
            shift_b <= converted(ch_b);
            conv_cnt[ch_a] <= conv_cnt[ch_a] + 1;
            conv_cnt[ch_b] <= conv_cnt[ch_b] + 1;
        end else begin
            shift_a <= {shift_a[adc_pkg::W_DATA-2:0], 1'b0};
            shift_b <= {shift_b[adc_pkg::W_DATA-2:0], 1'b0};
        end
    end

    assign sdo_a = shift_a[adc_pkg::W_DATA-1];
    assign sdo_b = shift_b[adc_pkg::W_DATA-1];

endmodule

`default_nettype wire

// File: sim/adc_frontend_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module adc_frontend_assertions (
    input wire logic                      sync_clk_in,
    input wire logic                      reset_in,
    input wire logic                      cnv,
    input wire logic                      sclk,
    // serializer strobe and channel
    input wire logic                      dv_out,
    input wire logic [adc_pkg::W_CHS-1:0] chan_out,
    input wire logic                      result_valid
);

    // failed assertion count, read by the testbench at the end
    int assert_fails = 0;

    // sclk stays put while the conversion pulse is high
    assert property (@(posedge sync_clk_in) disable iff (reset_in)
        (sclk != $past(sclk)) |-> !cnv)
        else begin
            assert_fails++;
            $error("sclk toggled while cnv was high");
        end

    // one pair gives at most two strobes in a row
    assert property (@(posedge sync_clk_in) disable iff (reset_in)
        (dv_out && $past(dv_out)) |-> !$past(dv_out, 2))
        else begin
            assert_fails++;
            $error("dv_out high for more than two cycles");
        end

    // second word of a pair comes from chip b
    assert property (@(posedge sync_clk_in) disable iff (reset_in)
        (dv_out && $past(dv_out)) |-> (chan_out == $past(chan_out) + adc_pkg::N_MUX))
        else begin
            assert_fails++;
            $error("second word of a pair has the wrong channel");
        end

    // a result only follows a serializer strobe
    assert property (@(posedge sync_clk_in) disable iff (reset_in)
        result_valid |-> $past(dv_out))
        else begin
            assert_fails++;
            $error("result_valid without dv_out one cycle earlier");
        end

endmodule

`default_nettype wire

// File: rtl/adc_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module adc_frontend (
    input  wire logic                       sync_clk_in,
    input  wire logic                       reset_in,
    // converter pins
    input  wire logic                       sdo_a,
    input  wire logic                       sdo_b,
    output logic                            cnv,
    output logic                            sclk,
    output logic [adc_pkg::W_MUX-1:0]       mux_sel,
    // averaged results
    output logic                            result_valid,
    output logic [adc_pkg::W_CHS-1:0]       result_chan,
    output logic [adc_pkg::W_DATA-1:0]      result_data
);

    //////////////////////////////////////////////////////////////////////
    // internal links
    //////////////////////////////////////////////////////////////////////

    // controller to serializer, a held pair with a dv level
    logic                       dv;
    logic [adc_pkg::W_CHS-1:0]  chan_a;
    logic [adc_pkg::W_CHS-1:0]  chan_b;
    logic [adc_pkg::W_DATA-1:0] data_a;
    logic [adc_pkg::W_DATA-1:0] data_b;

    // serializer to filter, one word per strobe
    logic                       sync_dv;
    logic [adc_pkg::W_CHS-1:0]  sync_chan;
    logic [adc_pkg::W_DATA-1:0] sync_data;

    //////////////////////////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////////////////////////

    adc_controller u_controller (
        .sync_clk_in (sync_clk_in),
        .reset_in    (reset_in),
        .sdo_a       (sdo_a),
        .sdo_b       (sdo_b),
        .cnv         (cnv),
        .sclk        (sclk),
        .mux_sel     (mux_sel),
        .dv          (dv),
        .chan_a      (chan_a),
        .chan_b      (chan_b),
        .data_a      (data_a),
        .data_b      (data_b)
    );

    //////////////////////////////////////////////////////////////////////
    // processing
    //////////////////////////////////////////////////////////////////////

    clk_sync u_sync (
        .sync_clk_in (sync_clk_in),
        .reset_in    (reset_in),
        .dv_in       (dv),
        .chan_a_in   (chan_a),
        .chan_b_in   (chan_b),
        .data_a_in   (data_a),
        .data_b_in   (data_b),
        .dv_out      (sync_dv),
        .chan_out    (sync_chan),
        .data_out    (sync_data)
    );

    // results leave the block straight from the filter registers
    oversample_filter u_filter (
        .sync_clk_in  (sync_clk_in),
        .reset_in     (reset_in),
        .dv_in        (sync_dv),
        .chan_in      (sync_chan),
        .data_in      (sync_data),
        .result_valid (result_valid),
        .result_chan  (result_chan),
        .result_data  (result_data)
    );

endmodule

`default_nettype wire

// File: rtl/oversample_filter.sv
`timescale 1ns/1ps
`default_nettype none

module oversample_filter (
    input  wire logic                       sync_clk_in,
    input  wire logic                       reset_in,
    // one word per strobe from the serializer
    input  wire logic                       dv_in,
    input  wire logic [adc_pkg::W_CHS-1:0]  chan_in,
    input  wire logic [adc_pkg::W_DATA-1:0] data_in,
    // averaged result, one per channel per 2^OSR_LOG2 samples
    output logic                            result_valid,
    output logic [adc_pkg::W_CHS-1:0]       result_chan,
    output logic [adc_pkg::W_DATA-1:0]      result_data
);

    //////////////////////////////////////////////////////////////////////
    // per channel state
    //////////////////////////////////////////////////////////////////////

    // running sums
    logic [adc_pkg::W_ACC-1:0]    acc [adc_pkg::N_ADC];
    // samples taken so far in the current block
    logic [adc_pkg::OSR_LOG2-1:0] cnt [adc_pkg::N_ADC];

    // sum including the incoming sample
    logic [adc_pkg::W_ACC-1:0] sum;
    // incoming sample completes the block
    logic                      last_sample;

    //////////////////////////////////////////////////////////////////////
    // accumulate
    //////////////////////////////////////////////////////////////////////

    // the wider accumulator holds four full scale words
    assign sum = acc[chan_in] + {{adc_pkg::OSR_LOG2{1'b0}}, data_in};

    // counter all ones means this is sample 2^OSR_LOG2
    assign last_sample = &cnt[chan_in];

    always_ff @(posedge sync_clk_in) begin
        if (reset_in) begin
            for (int i = 0; i < adc_pkg::N_ADC; i++) begin
                acc[i] <= '0;
                cnt[i] <= '0;
            end
        end else if (dv_in) begin
            // counter wraps back to zero on the last sample
            cnt[chan_in] <= cnt[chan_in] + 1'b1;
            if (last_sample) begin
                // next block starts from an empty sum
                acc[chan_in] <= '0;
            end else begin
                acc[chan_in] <= sum;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // result
    //////////////////////////////////////////////////////////////////////

    // strobe one cycle after the completing sample
    always_ff @(posedge sync_clk_in) begin
        if (reset_in) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= dv_in && last_sample;
        end
    end

    // truncated mean, dropping the low OSR_LOG2 bits of the sum
    always_ff @(posedge sync_clk_in) begin
        if (dv_in && last_sample) begin
            result_chan <= chan_in;
            result_data <= sum[adc_pkg::W_ACC-1:adc_pkg::OSR_LOG2];
        end
    end

endmodule

`default_nettype wire

// File: rtl/clk_sync.sv
`timescale 1ns/1ps
`default_nettype none

module clk_sync (
    input  wire logic                       sync_clk_in,
    input  wire logic                       reset_in,
    // held pair from the controller
    input  wire logic                       dv_in,
    input  wire logic [adc_pkg::W_CHS-1:0]  chan_a_in,
    input  wire logic [adc_pkg::W_CHS-1:0]  chan_b_in,
    input  wire logic [adc_pkg::W_DATA-1:0] data_a_in,
    input  wire logic [adc_pkg::W_DATA-1:0] data_b_in,
    // one word per strobe to the filter
    output logic                            dv_out,
    output logic [adc_pkg::W_CHS-1:0]       chan_out,
    output logic [adc_pkg::W_DATA-1:0]      data_out
);

    //////////////////////////////////////////////////////////////////////
    // state and captured pair
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ST_WAIT_DVH,
        ST_HOLD,
        ST_SEND_A,
        ST_SEND_B,
        ST_WAIT_DVL
    } state_t;

    state_t state;

    logic [adc_pkg::W_CHS-1:0]  chan_a_q;
    logic [adc_pkg::W_CHS-1:0]  chan_b_q;
    logic [adc_pkg::W_DATA-1:0] data_a_q;
    logic [adc_pkg::W_DATA-1:0] data_b_q;

    //////////////////////////////////////////////////////////////////////
    // pair capture
    //////////////////////////////////////////////////////////////////////

    // latch on the first edge that sees dv high
    always_ff @(posedge sync_clk_in) begin
        if (state == ST_WAIT_DVH && dv_in) begin
            chan_a_q <= chan_a_in;
            chan_b_q <= chan_b_in;
            data_a_q <= data_a_in;
            data_b_q <= data_b_in;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sync_clk_in) begin
        if (reset_in) begin
            state <= ST_WAIT_DVH;
        end else begin
            case (state)
                ST_WAIT_DVH: begin
                    if (dv_in) begin
                        state <= ST_HOLD;
                    end
                end
                // one cycle for the captured words to settle
                ST_HOLD:   state <= ST_SEND_A;
                ST_SEND_A: state <= ST_SEND_B;
                ST_SEND_B: state <= ST_WAIT_DVL;
                ST_WAIT_DVL: begin
                    // a pair is sent once per dv level
                    if (!dv_in) begin
                        state <= ST_WAIT_DVH;
                    end
                end
                default: begin
                    state <= ST_WAIT_DVH;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output mux
    //////////////////////////////////////////////////////////////////////

    // zero outside the two send states
    always_comb begin
        dv_out   = 1'b0;
        chan_out = '0;
        data_out = '0;
        case (state)
            ST_SEND_A: begin
                dv_out   = 1'b1;
                chan_out = chan_a_q;
                data_out = data_a_q;
            end
            ST_SEND_B: begin
                dv_out   = 1'b1;
                chan_out = chan_b_q;
                data_out = data_b_q;
            end
            default: begin
                dv_out = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/adc_controller.sv
`timescale 1ns/1ps
`default_nettype none

module adc_controller (
    input  wire logic                       sync_clk_in,
    input  wire logic                       reset_in,
    // serial result bits, msb first
    input  wire logic                       sdo_a,
    input  wire logic                       sdo_b,
    // converter control, shared by both chips
    output logic                            cnv,
    output logic                            sclk,
    output logic [adc_pkg::W_MUX-1:0]       mux_sel,
    // held result pair for the serializer
    output logic                            dv,
    output logic [adc_pkg::W_CHS-1:0]       chan_a,
    output logic [adc_pkg::W_CHS-1:0]       chan_b,
    output logic [adc_pkg::W_DATA-1:0]      data_a,
    output logic [adc_pkg::W_DATA-1:0]      data_b
);

    //////////////////////////////////////////////////////////////////////
    // state and counters
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CONVERT,
        ST_SHIFT,
        ST_HOLD,
        ST_ADVANCE
    } state_t;

    state_t state;

    // times the conversion wait and the dv hold
    logic [adc_pkg::W_CYC-1:0] cycle_cnt;
    // counts finished sclk periods in the shift
    logic [adc_pkg::W_BIT-1:0] bit_cnt;

    //////////////////////////////////////////////////////////////////////
    // channel numbers
    //////////////////////////////////////////////////////////////////////

    // chip a channels follow mux_sel directly
    assign chan_a = {{(adc_pkg::W_CHS - adc_pkg::W_MUX){1'b0}}, mux_sel};
    // chip b is numbered one mux bank higher
    assign chan_b = chan_a + adc_pkg::CHAN_B_OFFSET;

    //////////////////////////////////////////////////////////////////////
    // serial shift registers
    //////////////////////////////////////////////////////////////////////

    // both words fill msb first on the cycle sclk rises
    // they stay untouched from the last bit until the next shift
    always_ff @(posedge sync_clk_in) begin
        if ((state == ST_CONVERT && cycle_cnt == adc_pkg::CONV_LAST) ||
            (state == ST_SHIFT && !sclk)) begin
            data_a <= {data_a[adc_pkg::W_DATA-2:0], sdo_a};
            data_b <= {data_b[adc_pkg::W_DATA-2:0], sdo_b};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // conversion sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sync_clk_in) begin
        if (reset_in) begin
            state     <= ST_IDLE;
            cnv       <= 1'b0;
            sclk      <= 1'b0;
            dv        <= 1'b0;
            mux_sel   <= '0;
            cycle_cnt <= '0;
            bit_cnt   <= '0;
        end else begin
            // cnv is a single cycle pulse
            cnv <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // mux_sel has settled for a cycle, start the conversion
                    cnv       <= 1'b1;
                    cycle_cnt <= '0;
                    state     <= ST_CONVERT;
                end
                ST_CONVERT: begin
                    if (cycle_cnt == adc_pkg::CONV_LAST) begin
                        // first rising sclk, msb is sampled with it
                        sclk    <= 1'b1;
                        bit_cnt <= '0;
                        state   <= ST_SHIFT;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                ST_SHIFT: begin
                    // sclk runs at half the system clock
                    sclk <= ~sclk;
                    if (sclk) begin
                        if (bit_cnt == adc_pkg::BIT_LAST) begin
                            // last falling edge, words are complete
                            dv        <= 1'b1;
                            cycle_cnt <= '0;
                            state     <= ST_HOLD;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_HOLD: begin
                    // dv stays high long enough for the serializer
                    if (cycle_cnt == adc_pkg::HOLD_LAST) begin
                        dv    <= 1'b0;
                        state <= ST_ADVANCE;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                ST_ADVANCE: begin
                    // idle cycle, then step to the next mux input
                    if (mux_sel == adc_pkg::MUX_LAST) begin
                        mux_sel <= '0;
                    end else begin
                        mux_sel <= mux_sel + 1'b1;
                    end
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/adc_pkg.sv
`default_nettype none

package adc_pkg;

    //////////////////////////////////////////////////////////////////////
    // data path widths
    //////////////////////////////////////////////////////////////////////

    // one converter result word
    localparam int W_DATA = 18;
    // channel number carried with each word
    localparam int W_CHS = 3;
    // channels over both chips
    localparam int N_ADC = 8;
    // analog mux inputs per chip, chip b channels sit N_MUX above chip a
    localparam int N_MUX = 4;
    localparam int W_MUX = 2;

    //////////////////////////////////////////////////////////////////////
    // controller timing
    //////////////////////////////////////////////////////////////////////

    // cycles from the cnv pulse to the first rising sclk
    localparam int CONV_CYCLES = 6;
    // dv level length, the serializer needs at least 4
    localparam int DV_HOLD_CYCLES = 4;

    // counter widths
    localparam int W_CYC = $clog2((CONV_CYCLES > DV_HOLD_CYCLES) ? CONV_CYCLES : DV_HOLD_CYCLES);
    localparam int W_BIT = $clog2(W_DATA);

    // terminal counts, sized to match the counters
    localparam logic [W_CYC-1:0] CONV_LAST = W_CYC'(CONV_CYCLES - 1);
    localparam logic [W_CYC-1:0] HOLD_LAST = W_CYC'(DV_HOLD_CYCLES - 1);
    localparam logic [W_BIT-1:0] BIT_LAST = W_BIT'(W_DATA - 1);
    localparam logic [W_MUX-1:0] MUX_LAST = W_MUX'(N_MUX - 1);
    localparam logic [W_CHS-1:0] CHAN_B_OFFSET = W_CHS'(N_MUX);

    //////////////////////////////////////////////////////////////////////
    // oversampling
    //////////////////////////////////////////////////////////////////////

    // four samples per result
    localparam int OSR_LOG2 = 2;
    // room for the full sum without overflow
    localparam int W_ACC = W_DATA + OSR_LOG2;

endpackage

`default_nettype wire
